//--- flist.f
src/apb_seq_pkg.sv
src/cmd_store.sv
src/apb_master.sv
src/seq_control.sv
src/apb_seq_top.sv
tests/tb_apb_seq_assert.sv
tests/tb_apb_seq.sv

//--- src/apb_master.sv
`timescale 1ns/1ps

module apb_master import apb_seq_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue,
    input  logic              xfer_write,
    input  logic [addr_w-1:0] xfer_addr,
    input  logic [data_w-1:0] xfer_wdata,
    output logic              xfer_done,
    output logic              xfer_err,
    output logic              xfer_rdata_nz,
    output logic [addr_w-1:0] paddr,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output logic [data_w-1:0] pwdata,
    input  logic              pready,
    input  logic [data_w-1:0] prdata,
    input  logic              pslverr
);

    logic access_end;

    // Last access cycle
    assign access_end = psel && penable && pready;

    // psel and penable encode idle, setup and access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else begin
            if (issue) begin
                psel    <= 1'b1;
                penable <= 1'b0;
                pwrite  <= xfer_write;
            end else if (psel && !penable) begin
                penable <= 1'b1;
            end else if (access_end) begin
                psel    <= 1'b0;
                penable <= 1'b0;
            end
        end
    end

    // Address and data held until the next request
    always_ff @(posedge clk) begin
        if (issue) begin
            paddr  <= xfer_addr;
            pwdata <= xfer_wdata;
        end
    end

    // Completion reported in the cycle pready is sampled
    assign xfer_done     = access_end;
    assign xfer_err      = pslverr;
    assign xfer_rdata_nz = |prdata;

endmodule

//--- src/apb_seq_pkg.sv
package apb_seq_pkg;

    // Bus and program sizes
    localparam int addr_w     = 16;
    localparam int data_w     = 32;
    localparam int prog_depth = 32;
    localparam int pc_w       = 5;
    localparam int op_w       = 3;
    localparam int cmd_w      = op_w + addr_w + data_w;

    // Any other opcode is rejected at decode
    localparam logic [op_w-1:0] op_write  = 3'd0;
    localparam logic [op_w-1:0] op_read   = 3'd1;
    localparam logic [op_w-1:0] op_branch = 3'd2;
    localparam logic [op_w-1:0] op_goto   = 3'd3;

    // Sequencer FSM encoding
    localparam int st_w = 3;
    localparam logic [st_w-1:0] st_idle      = 3'd0;
    localparam logic [st_w-1:0] st_decode    = 3'd1;
    localparam logic [st_w-1:0] st_wait_xfer = 3'd2;
    localparam logic [st_w-1:0] st_finished  = 3'd3;
    localparam logic [st_w-1:0] st_failed    = 3'd4;

    // One command word read as a bus access or as a jump
    typedef union packed {
        struct packed {
            logic [op_w-1:0]   op;
            logic [addr_w-1:0] addr;
            logic [data_w-1:0] wdata;
        } acc;
        struct packed {
            logic [op_w-1:0]              op;
            logic [pc_w-1:0]              target;
            logic [cmd_w-op_w-pc_w-1:0]   pad;
        } jmp;
    } cmd_word_u;

endpackage

//--- src/apb_seq_top.sv
`timescale 1ns/1ps

module apb_seq_top import apb_seq_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_en,
    input  logic [pc_w-1:0]   load_addr,
    input  cmd_word_u         load_word,
    input  logic [pc_w:0]     prog_len,
    input  logic              start,
    output logic              done,
    output logic              error,
    output logic [addr_w-1:0] paddr,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output logic [data_w-1:0] pwdata,
    input  logic              pready,
    input  logic [data_w-1:0] prdata,
    input  logic              pslverr
);

    logic [pc_w-1:0]   pc;
    cmd_word_u         fetch_word;
    logic              issue;
    logic              xfer_write;
    logic [addr_w-1:0] xfer_addr;
    logic [data_w-1:0] xfer_wdata;
    logic              xfer_done;
    logic              xfer_err;
    logic              xfer_rdata_nz;

    cmd_store u_store (
        .clk        (clk),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_word  (load_word),
        .pc         (pc),
        .fetch_word (fetch_word)
    );

    seq_control u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .prog_len      (prog_len),
        .fetch_word    (fetch_word),
        .pc            (pc),
        .issue         (issue),
        .xfer_write    (xfer_write),
        .xfer_addr     (xfer_addr),
        .xfer_wdata    (xfer_wdata),
        .xfer_done     (xfer_done),
        .xfer_err      (xfer_err),
        .xfer_rdata_nz (xfer_rdata_nz),
        .done          (done),
        .error         (error)
    );

    apb_master u_apb (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue         (issue),
        .xfer_write    (xfer_write),
        .xfer_addr     (xfer_addr),
        .xfer_wdata    (xfer_wdata),
        .xfer_done     (xfer_done),
        .xfer_err      (xfer_err),
        .xfer_rdata_nz (xfer_rdata_nz),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .pready        (pready),
        .prdata        (prdata),
        .pslverr       (pslverr)
    );

endmodule

//--- src/cmd_store.sv
`timescale 1ns/1ps

module cmd_store import apb_seq_pkg::*; (
    input  logic            clk,
    input  logic            load_en,
    input  logic [pc_w-1:0] load_addr,
    input  cmd_word_u       load_word,
    input  logic [pc_w-1:0] pc,
    output cmd_word_u       fetch_word
);

    // Program memory filled before start
    cmd_word_u mem [prog_depth];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_word;
        end
    end

    // Fetch is combinational so decode sees the word at pc in the same cycle
    assign fetch_word = mem[pc];

endmodule

//--- src/seq_control.sv
`timescale 1ns/1ps

module seq_control import apb_seq_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [pc_w:0]     prog_len,
    input  cmd_word_u         fetch_word,
    output logic [pc_w-1:0]   pc,
    output logic              issue,
    output logic              xfer_write,
    output logic [addr_w-1:0] xfer_addr,
    output logic [data_w-1:0] xfer_wdata,
    input  logic              xfer_done,
    input  logic              xfer_err,
    input  logic              xfer_rdata_nz,
    output logic              done,
    output logic              error
);

    logic [st_w-1:0] state;
    // One bit wider than pc so a full 32 entry program can reach its end
    logic [pc_w:0]   pc_cnt;
    logic [pc_w:0]   pc_inc;
    logic            branch_flag;
    logic            rd_pending;
    logic            at_end;
    logic            is_access;

    assign pc     = pc_cnt[pc_w-1:0];
    assign pc_inc = pc_cnt + 1'b1;
    assign at_end = pc_cnt >= prog_len;

    assign is_access = (fetch_word.acc.op == op_write) || (fetch_word.acc.op == op_read);

    // Request to the APB master straight from the fetched word
    assign issue      = (state == st_decode) && !at_end && is_access;
    assign xfer_write = fetch_word.acc.op == op_write;
    assign xfer_addr  = fetch_word.acc.addr;
    assign xfer_wdata = fetch_word.acc.wdata;

    assign done  = state == st_finished;
    assign error = state == st_failed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            pc_cnt      <= '0;
            branch_flag <= 1'b0;
            rd_pending  <= 1'b0;
        end else begin
            case (state)
                st_idle, st_finished, st_failed: begin
                    if (start) begin
                        state  <= st_decode;
                        pc_cnt <= '0;
                    end
                end

                st_decode: begin
                    if (at_end) begin
                        state <= st_finished;
                    end else begin
                        case (fetch_word.acc.op)
                            op_write, op_read: begin
                                rd_pending <= fetch_word.acc.op == op_read;
                                state      <= st_wait_xfer;
                            end
                            op_goto: begin
                                pc_cnt <= {1'b0, fetch_word.jmp.target};
                            end
                            op_branch: begin
                                if (branch_flag) begin
                                    pc_cnt <= {1'b0, fetch_word.jmp.target};
                                end else begin
                                    pc_cnt <= pc_inc;
                                end
                            end
                            default: begin
                                state <= st_failed;
                            end
                        endcase
                    end
                end

                st_wait_xfer: begin
                    if (xfer_done) begin
                        if (xfer_err) begin
                            state <= st_failed;
                        end else begin
                            // Branch condition only follows reads
                            if (rd_pending) begin
                                branch_flag <= xfer_rdata_nz;
                            end
                            pc_cnt <= pc_inc;
                            state  <= st_decode;
                        end
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- tests/apb_seq_testdata.txt
// First entry is the test count. Per test, a header line: words transfers ending (0 done, 1 error)
// then the program words {op, addr, wdata} in hex, then one line per transfer: write addr data
8
3 2 0  // branch before any read falls through
2100000000000 0000811111111 0000c22222222
1 0008 11111111
1 000c 22222222
6 6 0  // straight-line writes then reads
0001012345678 00014a5a5a5a5 0000400000001 1001000000000 1001400000000 1000400000000
1 0010 12345678
1 0014 a5a5a5a5
1 0004 00000001
0 0010 12345678
0 0014 a5a5a5a5
0 0004 00000001
4 2 0  // goto skips one write
00000aaaa0001 3180000000000 00004bad00bad 1000000000000
1 0000 aaaa0001
0 0000 aaaa0001
5 3 0  // branch taken after a non-zero read
0000800000005 1000800000000 2200000000000 0000cdeadbeef 000100000cafe
1 0008 00000005
0 0008 00000005
1 0010 0000cafe
4 3 0  // branch falls through after a zero read
1002000000000 2180000000000 0002400000077 1002400000000
0 0020 00000000
1 0024 00000077
0 0024 00000077
3 2 1  // slave error stops the program
0003000000042 0ff0000000001 0003400000099
1 0030 00000042
1 ff00 00000001
2 0 1  // invalid opcode, no transfer
5000000000000 0003800000001
2 2 0  // restart after error
0003c0000abcd 1003c00000000
1 003c 0000abcd
0 003c 0000abcd

//--- tests/tb_apb_seq.sv
`timescale 1ns/1ps

module tb_apb_seq import apb_seq_pkg::*; ();

    localparam int period       = 40;
    localparam int reset_cycles = 8;

    logic              clk;
    logic              rst_n;
    logic              load_en;
    logic [pc_w-1:0]   load_addr;
    cmd_word_u         load_word;
    logic [pc_w:0]     prog_len;
    logic              start;
    logic              done;
    logic              error;
    logic [addr_w-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [data_w-1:0] pwdata;
    logic              pready;
    logic [data_w-1:0] prdata;
    logic              pslverr;

    // Test data words and the slave's register file
    logic [63:0]       tdata [512];
    logic [data_w-1:0] slave_mem [16];
    integer            seed = 32'h72fd28bc;
    int                num_tests;
    int                errors;
    int                exp_base;
    int                exp_count;
    int                seen;

    apb_seq_top dut (.*);

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic load_program(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            load_en   = 1'b1;
            load_addr = pc_w'(i);
            load_word = tdata[first + i][cmd_w-1:0];
            next_cycle();
        end
        load_en = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    initial begin
        longint limit_ns;
        #1;
        limit_ns = longint'(num_tests) * 32 * 8 * period + reset_cycles * period;
        #(limit_ns);
        $display("Timeout: run did not finish within %0d ns", limit_ns);
        $display("TESTS FAILED");
        $finish;
    end

    // APB slave with 0 to 3 wait cycles that checks each completed transfer
    initial begin
        int          wait_left;
        int          slot;
        logic [63:0] exp_write;
        logic [63:0] exp_addr;
        logic [63:0] exp_data;
        pready    = 1'b0;
        prdata    = '0;
        pslverr   = 1'b0;
        wait_left = 0;
        forever begin
            next_cycle();
            pready  = 1'b0;
            prdata  = '0;
            pslverr = 1'b0;
            if (psel && !penable) begin
                wait_left = $unsigned($random(seed)) % 4;
            end else if (psel && penable && wait_left > 0) begin
                wait_left--;
            end else if (psel && penable) begin
                pready = 1'b1;
                slot   = paddr[5:2];
                if (paddr >= 16'hff00) begin
                    pslverr = 1'b1;
                end else if (pwrite) begin
                    slave_mem[slot] = pwdata;
                end else begin
                    prdata = slave_mem[slot];
                end
                if (seen >= exp_count) begin
                    $display("Unexpected transfer at %0t to address %h", $time, paddr);
                    errors++;
                end else begin
                    exp_write = tdata[exp_base + 3 * seen];
                    exp_addr  = tdata[exp_base + 3 * seen + 1];
                    exp_data  = tdata[exp_base + 3 * seen + 2];
                    if (pwrite !== exp_write[0]) begin
                        $display("Fail at %0t: pwrite got %0b expected %0b",
                                 $time, pwrite, exp_write[0]);
                        errors++;
                    end
                    if (paddr !== exp_addr[addr_w-1:0]) begin
                        $display("Fail at %0t: paddr got %h expected %h",
                                 $time, paddr, exp_addr[addr_w-1:0]);
                        errors++;
                    end
                    if (exp_write[0] && pwdata !== exp_data[data_w-1:0]) begin
                        $display("Fail at %0t: pwdata got %h expected %h",
                                 $time, pwdata, exp_data[data_w-1:0]);
                        errors++;
                    end
                    if (!exp_write[0] && prdata !== exp_data[data_w-1:0]) begin
                        $display("Fail at %0t: prdata got %h expected %h",
                                 $time, prdata, exp_data[data_w-1:0]);
                        errors++;
                    end
                end
                seen++;
            end
        end
    end

    initial begin
        int ptr;
        int nwords;
        int ending;
        int errors_before;
        int failing;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_word = '0;
        prog_len  = '0;
        start     = 1'b0;
        errors    = 0;
        failing   = 0;
        seen      = 0;
        exp_base  = 0;
        exp_count = 0;
        $readmemh("tests/apb_seq_testdata.txt", tdata);
        num_tests = int'(tdata[0]);
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        if (psel !== 1'b0) begin
            $display("Fail at %0t: psel got %0b expected 0", $time, psel);
            errors++;
        end
        if (penable !== 1'b0) begin
            $display("Fail at %0t: penable got %0b expected 0", $time, penable);
            errors++;
        end
        if (done !== 1'b0) begin
            $display("Fail at %0t: done got %0b expected 0", $time, done);
            errors++;
        end
        if (error !== 1'b0) begin
            $display("Fail at %0t: error got %0b expected 0", $time, error);
            errors++;
        end
        if (num_tests == 0) begin
            $display("No tests found in the test data file");
            errors++;
        end
        ptr = 1;
        for (int t = 0; t < num_tests; t++) begin
            errors_before = errors;
            nwords        = int'(tdata[ptr]);
            ending        = int'(tdata[ptr + 2]);
            load_program(ptr + 3, nwords);
            for (int i = 0; i < 16; i++) begin
                slave_mem[i] = '0;
            end
            exp_base  = ptr + 3 + nwords;
            exp_count = int'(tdata[ptr + 1]);
            seen      = 0;
            ptr       = exp_base + 3 * exp_count;
            prog_len  = (pc_w + 1)'(nwords);
            start     = 1'b1;
            next_cycle();
            start = 1'b0;
            while (!done && !error) begin
                next_cycle();
            end
            // Idle window so a stray transfer would still be seen
            repeat (4) next_cycle();
            if (ending == 0 && (done !== 1'b1 || error !== 1'b0)) begin
                $display("Test %0d should end in done, saw done=%0b error=%0b", t, done, error);
                errors++;
            end
            if (ending != 0 && (error !== 1'b1 || done !== 1'b0)) begin
                $display("Test %0d should end in error, saw done=%0b error=%0b", t, done, error);
                errors++;
            end
            if (seen < exp_count) begin
                $display("Test %0d missed %0d expected transfers", t, exp_count - seen);
                errors++;
            end
            if (errors == errors_before) begin
                $display("Test %0d passed", t);
            end else begin
                $display("Test %0d failed", t);
                failing++;
            end
        end
        $display("Summary: %0d tests, %0d failing, %0d check errors, %0d assertion failures",
                 num_tests, failing, errors, dut.u_apb.u_assert.assert_fails);
        errors += dut.u_apb.u_assert.assert_fails;
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/tb_apb_seq_assert.sv
`timescale 1ns/1ps

module tb_apb_seq_assert import apb_seq_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              psel,
    input logic              penable,
    input logic              pwrite,
    input logic [addr_w-1:0] paddr,
    input logic [data_w-1:0] pwdata
);

    int assert_fails = 0;

    // Setup phase lasts exactly one cycle
    setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(psel) |=> $rose(penable))
        else begin
            $error("penable did not rise one cycle after psel");
            assert_fails++;
        end

    access_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past($rose(psel)))
        else begin
            $error("penable rose without a setup cycle");
            assert_fails++;
        end

    // Request fields frozen for the whole transfer
    fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && $past(psel)) |-> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else begin
            $error("paddr, pwrite or pwdata changed while psel was high");
            assert_fails++;
        end

    enable_needs_sel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
        else begin
            $error("penable high without psel");
            assert_fails++;
        end

endmodule

bind apb_master tb_apb_seq_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata)
);
